/* all.f */
verilog/axf_pkg.sv
verilog/axf_regfile.sv
verilog/axf_engine.sv
verilog/axf_readback.sv
verilog/axf_top.sv
tb/axf_assert.sv
tb/axf_tb.sv

/* Bender.yml */
package:
  name: axf

sources:
  - verilog/axf_pkg.sv
  - verilog/axf_regfile.sv
  - verilog/axf_engine.sv
  - verilog/axf_readback.sv
  - verilog/axf_top.sv
  - target: test
    files:
      - tb/axf_assert.sv
      - tb/axf_tb.sv

/* tb/axf_tb.sv */
// Testbench for the affine transform unit
// Clock, reset, bus write and read tasks, reference model of the
// transformed point, value checks, per-test reports and a watchdog

`default_nettype none

module axf_tb
        import axf_pkg::*;
();
        timeunit 1ns;
        timeprecision 1ps;

        localparam int          CLK_PERIOD    = 20;
        localparam int          RESET_CYCLES  = 3;
        localparam logic [31:0] SEED          = 32'h0eb88dae;
        localparam int          RANDOM_RUNS   = 12;
        localparam int          NUM_RUNS      = RANDOM_RUNS + 8;        // All runs and sweeps
        localparam int          RUN_CYCLES    = 20;
        localparam int          MARGIN_CYCLES = 100;
        localparam int          BUSY_CYCLES   = 5;
        localparam int          DONE_LIMIT    = 20;
        localparam write_size_t WR_WORD       = 2'b10;

        logic           clk;
        logic           rst_n;
        reg_addr_t      address_i;
        bus_data_t      data_in_i;
        write_size_t    data_write_n_i;
        bus_data_t      data_out_o;

        int             checks;
        int             errors;
        int             tests;
        int             failed_tests;

        axf_top axf_top_inst (
                .clk            (clk),
                .rst_n          (rst_n),
                .address_i      (address_i),
                .data_in_i      (data_in_i),
                .data_write_n_i (data_write_n_i),
                .data_out_o     (data_out_o)
        );

        initial begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        initial begin
                #((NUM_RUNS * RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
                $display("watchdog: run did not finish in time, stopping");
                $display("ERRORS FOUND");
                $finish;
        end

        // One Q8.8 row with each product floored by 2^-8 before the wrapped sum
        function automatic coord_t model_row(input coord_t c0, input coord_t v0,
                                             input coord_t c1, input coord_t v1,
                                             input coord_t t);
                longint p0;
                longint p1;
                longint sum;
                p0  = longint'(c0) * longint'(v0);
                p1  = longint'(c1) * longint'(v1);
                sum = (p0 >>> 8) + (p1 >>> 8) + longint'(t);
                return coord_t'(sum);
        endfunction

        function automatic bus_data_t sext(input coord_t v);
                return {{16{v[15]}}, v};
        endfunction

        // Caller sits just after a rising edge and the write lands on the next one
        task automatic bus_write(input reg_addr_t addr, input bus_data_t data);
                address_i      <= addr;
                data_in_i      <= data;
                data_write_n_i <= WR_WORD;
                @(posedge clk);
                data_write_n_i <= NO_WRITE;
        endtask

        task automatic bus_read(input reg_addr_t addr, output bus_data_t data);
                address_i <= addr;
                @(negedge clk);
                data = data_out_o;                      // Settled mid-cycle
                @(posedge clk);
        endtask

        task automatic check_value(input reg_addr_t addr, input bus_data_t got,
                                   input bus_data_t exp);
                checks++;
                assert (got === exp)
                else begin
                        $display("error: data_out_o at offset %h: got %h, expected %h",
                                 addr, got, exp);
                        errors++;
                end
        endtask

        task automatic check_read(input reg_addr_t addr, input bus_data_t exp);
                bus_data_t rd;
                bus_read(addr, rd);
                check_value(addr, rd, exp);
        endtask

        // Polls status once per cycle, counting the reads that show busy
        task automatic wait_done(output int busy_reads);
                bus_data_t st;
                busy_reads = 0;
                bus_read(ADDR_STATUS, st);
                while (!st[STAT_DONE_BIT] && busy_reads < DONE_LIMIT) begin
                        check_value(ADDR_STATUS, st, bus_data_t'(1) << STAT_BUSY_BIT);
                        busy_reads++;
                        bus_read(ADDR_STATUS, st);
                end
                check_value(ADDR_STATUS, st, bus_data_t'(1) << STAT_DONE_BIT);
        endtask

        task automatic start_run(input bit extra_start);
                int n;
                int exp_n;
                bus_write(ADDR_CONTROL, 32'h1);
                if (extra_start)
                        bus_write(ADDR_CONTROL, 32'h5);  // Arrives in the first busy cycle
                exp_n = BUSY_CYCLES - int'(extra_start);
                wait_done(n);
                checks++;
                assert (n == exp_n)
                else begin
                        $display("busy was seen for %0d cycles instead of %0d", n, exp_n);
                        errors++;
                end
        endtask

        task automatic load_operands(input affine_coef_t c, input point_t p);
                bus_write(ADDR_A, bus_data_t'(c.a));
                bus_write(ADDR_B, bus_data_t'(c.b));
                bus_write(ADDR_D, bus_data_t'(c.d));
                bus_write(ADDR_E, bus_data_t'(c.e));
                bus_write(ADDR_TX, bus_data_t'(c.tx));
                bus_write(ADDR_TY, bus_data_t'(c.ty));
                bus_write(ADDR_XIN, {16'hA5A5, p.x});   // Upper half is ignored
                bus_write(ADDR_YIN, {16'h5A5A, p.y});
        endtask

        task automatic check_result(input affine_coef_t c, input point_t p);
                check_read(ADDR_XOUT, sext(model_row(c.a, p.x, c.b, p.y, c.tx)));
                check_read(ADDR_YOUT, sext(model_row(c.d, p.x, c.e, p.y, c.ty)));
        endtask

        task automatic identity_case(input coord_t tx, input coord_t ty, input point_t p);
                affine_coef_t c;
                c = '{a: 16'h0100, b: 16'h0000, d: 16'h0000, e: 16'h0100, tx: tx, ty: ty};
                load_operands(c, p);
                start_run(1'b0);
                check_read(ADDR_XOUT, sext(coord_t'(p.x + tx)));
                check_read(ADDR_YOUT, sext(coord_t'(p.y + ty)));
        endtask

        task automatic end_test(input string name, input int errors_before);
                tests++;
                if (errors == errors_before) begin
                        $display("test %s: ok", name);
                end else begin
                        failed_tests++;
                        $display("test %s: %0d failed checks", name, errors - errors_before);
                end
        endtask

        initial begin
                int             mark;
                int             total_errors;
                affine_coef_t   c;
                point_t         p;
                rst_n          = 1'b0;
                address_i      = '0;
                data_in_i      = '0;
                data_write_n_i = NO_WRITE;
                checks         = 0;
                errors         = 0;
                tests          = 0;
                failed_tests   = 0;
                void'($urandom(SEED));
                repeat (RESET_CYCLES) @(posedge clk);
                rst_n <= 1'b1;
                @(posedge clk);

                mark = errors;
                for (int off = 'h00; off <= 'h2C; off += 4)
                        check_read(reg_addr_t'(off), '0);
                end_test("reset values", mark);

                mark = errors;
                identity_case(16'h0123, 16'hFF00, '{x: 16'h0250, y: 16'h0010});
                identity_case(16'h7000, 16'h8000, '{x: 16'h2000, y: 16'h8000});  // Both wrap
                end_test("identity with translation", mark);

                mark = errors;
                for (int i = 0; i < RANDOM_RUNS; i++) begin
                        c = affine_coef_t'({$urandom(), $urandom(), $urandom()});
                        p = point_t'($urandom());
                        load_operands(c, p);
                        start_run(1'b0);
                        check_result(c, p);
                end
                end_test("random transforms", mark);

                mark = errors;
                c = '{a: 16'h0180, b: 16'hFFC0, d: 16'h0040, e: 16'hFF00,
                      tx: 16'h0100, ty: 16'h0003};
                p = '{x: 16'hF080, y: 16'h0321};
                load_operands(c, p);
                start_run(1'b0);
                check_result(c, p);
                p = '{x: 16'h1234, y: 16'hCDEF};
                bus_write(ADDR_XIN, bus_data_t'(p.x));
                bus_write(ADDR_YIN, bus_data_t'(p.y));
                start_run(1'b0);                        // Done must drop during this run
                check_result(c, p);
                end_test("status timing", mark);

                mark = errors;
                c = '{a: 16'hFF80, b: 16'h0040, d: 16'h0200, e: 16'hFE00,
                      tx: 16'h0011, ty: 16'hFFEE};
                p = '{x: 16'h0300, y: 16'hFD00};
                load_operands(c, p);
                start_run(1'b1);
                check_result(c, p);
                check_read(ADDR_CONTROL, 32'h5);
                bus_write(ADDR_CONTROL, 32'hFFFF_FFFA);
                check_read(ADDR_CONTROL, 32'h2);
                check_read(ADDR_STATUS, bus_data_t'(1) << STAT_DONE_BIT);
                for (int off = 'h30; off <= 'h3C; off += 4)
                        check_read(reg_addr_t'(off), '0);
                end_test("start while busy and register map", mark);

                total_errors = errors + int'(axf_top_inst.axf_assert_inst.fail_count);
                $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                         tests, failed_tests, checks, errors,
                         axf_top_inst.axf_assert_inst.fail_count);
                if (total_errors == 0)
                        $display("NO ERRORS");
                else
                        $display("ERRORS FOUND");
                $finish;
        end

endmodule

`default_nettype wire

/* tb/axf_assert.sv */
// Concurrent timing checks for the affine transform unit
// Busy length after an accepted start, position of result_valid,
// and starts that arrive while the engine is busy

`default_nettype none

module axf_assert
        import axf_pkg::*;
(
        input  wire logic       clk,
        input  wire logic       rst_n,
        input  wire logic       start_i,
        input  wire logic       busy_i,
        input  wire logic       result_valid_i
);
        timeunit 1ns;
        timeprecision 1ps;

        localparam int BUSY_CYCLES = MUL_STEPS + 1;     // MULT steps plus ADD_SHIFT

        int unsigned    fail_count = 0;                 // Failed assertions so far
        logic           accepted;

        assign accepted = start_i && !busy_i;

        busy_len: assert property (@(posedge clk) disable iff (!rst_n)
                accepted |=> busy_i [*BUSY_CYCLES] ##1 !busy_i)
        else begin
                $error("busy did not last exactly %0d cycles after a start", BUSY_CYCLES);
                fail_count++;
        end

        valid_pos: assert property (@(posedge clk) disable iff (!rst_n)
                accepted |=> !result_valid_i [*MUL_STEPS] ##1 result_valid_i)
        else begin
                $error("result_valid did not follow the four multiply cycles");
                fail_count++;
        end

        // A start that lands mid-run must not stretch the run
        late_start: assert property (@(posedge clk) disable iff (!rst_n)
                start_i && busy_i |-> ##[0:MUL_STEPS] result_valid_i ##1 !busy_i)
        else begin
                $error("a start during busy extended the run");
                fail_count++;
        end

        valid_ends_busy: assert property (@(posedge clk) disable iff (!rst_n)
                result_valid_i |=> !busy_i)
        else begin
                $error("busy still high after result_valid");
                fail_count++;
        end

endmodule

bind axf_top axf_assert axf_assert_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start),
        .busy_i         (busy),
        .result_valid_i (result_valid)
);

`default_nettype wire

/* verilog/axf_top.sv */
// Top level of the memory-mapped affine transform unit
// Register file, multiply-accumulate engine and read-back stage
// joined to the bus ports

`default_nettype none

module axf_top
        import axf_pkg::*;
(
        input  wire logic               clk,
        input  wire logic               rst_n,
        input  wire reg_addr_t          address_i,
        input  wire bus_data_t          data_in_i,
        input  wire write_size_t        data_write_n_i,
        output bus_data_t               data_out_o
);

        affine_coef_t           coef;
        point_t                 point_in;
        logic [CTRL_BITS-1:0]   ctrl;
        logic                   start;          // Pulse from a control write

        logic                   busy;
        point_t                 result;
        logic                   result_valid;   // Qualifies result

        axf_regfile regfile_inst (
                .clk            (clk),
                .rst_n          (rst_n),
                .address_i      (address_i),
                .data_in_i      (data_in_i),
                .data_write_n_i (data_write_n_i),
                .coef_o         (coef),
                .point_o        (point_in),
                .ctrl_o         (ctrl),
                .start_o        (start)
        );

        axf_engine engine_inst (
                .clk            (clk),
                .rst_n          (rst_n),
                .start_i        (start),
                .coef_i         (coef),
                .point_i        (point_in),
                .busy_o         (busy),
                .result_o       (result),
                .result_valid_o (result_valid)
        );

        axf_readback readback_inst (
                .clk            (clk),
                .rst_n          (rst_n),
                .address_i      (address_i),
                .ctrl_i         (ctrl),
                .busy_i         (busy),
                .result_i       (result),
                .result_valid_i (result_valid),
                .data_out_o     (data_out_o)
        );

endmodule

`default_nettype wire

/* verilog/axf_readback.sv */
// Read side of the affine transform unit
// Output point and done flag registers, status word,
// and the combinational read multiplexer

`default_nettype none

module axf_readback
        import axf_pkg::*;
(
        input  wire logic               clk,
        input  wire logic               rst_n,
        input  wire reg_addr_t          address_i,
        input  wire logic [CTRL_BITS-1:0] ctrl_i,
        input  wire logic               busy_i,
        input  wire point_t             result_i,
        input  wire logic               result_valid_i,
        output bus_data_t               data_out_o
);

        point_t         result_q;
        logic           done_q;
        bus_data_t      status_word;

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        result_q <= '0;
                        done_q   <= 1'b0;
                end else if (result_valid_i) begin
                        result_q <= result_i;   // Last cycle of the run
                        done_q   <= 1'b1;
                end else if (busy_i) begin
                        done_q   <= 1'b0;
                end
        end

        // Done reads 0 as soon as a new run is under way
        always_comb begin
                status_word                = '0;
                status_word[STAT_DONE_BIT] = done_q && !busy_i;
                status_word[STAT_BUSY_BIT] = busy_i;
        end

        always_comb begin
                case (address_i)
                        ADDR_CONTROL: data_out_o = {{(DATA_W - CTRL_BITS){1'b0}}, ctrl_i};
                        ADDR_STATUS:  data_out_o = status_word;
                        ADDR_XOUT:    data_out_o = {{(DATA_W - COORD_W){result_q.x[COORD_W-1]}},
                                                    result_q.x};
                        ADDR_YOUT:    data_out_o = {{(DATA_W - COORD_W){result_q.y[COORD_W-1]}},
                                                    result_q.y};
                        default:      data_out_o = '0;
                endcase
        end

endmodule

`default_nettype wire

/* verilog/axf_engine.sv */
// Multiply-accumulate engine of the affine transform unit
// One shared signed multiplier forms a*x, b*y, d*x and e*y over four
// MULT cycles, then ADD_SHIFT scales, sums and translates the point

`default_nettype none

module axf_engine
        import axf_pkg::*;
(
        input  wire logic               clk,
        input  wire logic               rst_n,
        input  wire logic               start_i,
        input  wire affine_coef_t       coef_i,
        input  wire point_t             point_i,
        output logic                    busy_o,
        output point_t                  result_o,
        output logic                    result_valid_o
);

        eng_state_t     state_q;
        eng_state_t     state_d;
        step_t          step_q;
        logic           last_step;

        coord_t         op_coef;        // Multiplier operands
        coord_t         op_pt;
        prod_t          mul_res;
        prod_t          prod_q [MUL_STEPS];

        prod_t          sum_x;
        prod_t          sum_y;

        assign last_step = (step_q == step_t'(MUL_STEPS - 1));

        // Next state
        always_comb begin
                state_d = state_q;
                case (state_q)
                        IDLE: begin
                                if (start_i)
                                        state_d = MULT;
                        end
                        MULT: begin
                                if (last_step)
                                        state_d = ADD_SHIFT;
                        end
                        ADD_SHIFT: state_d = IDLE;
                        default:   state_d = IDLE;
                endcase
        end

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        state_q <= IDLE;
                        step_q  <= '0;
                end else begin
                        state_q <= state_d;
                        if (state_q == MULT)
                                step_q <= step_q + step_t'(1);
                        else
                                step_q <= '0;   // Ready for the next run
                end
        end

        // Operand order a*x, b*y, d*x, e*y
        always_comb begin
                case (step_q)
                        step_t'(0): op_coef = coef_i.a;
                        step_t'(1): op_coef = coef_i.b;
                        step_t'(2): op_coef = coef_i.d;
                        default:    op_coef = coef_i.e;
                endcase
                op_pt = step_q[0] ? point_i.y : point_i.x;
        end

        assign mul_res = $signed(op_coef) * $signed(op_pt);

        // One product per MULT cycle, indexed by the step counter
        always_ff @(posedge clk) begin
                if (state_q == MULT)
                        prod_q[step_q] <= mul_res;
        end

        // Each product is scaled on its own before the sum
        assign sum_x = (prod_q[0] >>> FRAC_BITS) + (prod_q[1] >>> FRAC_BITS)
                     + prod_t'($signed(coef_i.tx));
        assign sum_y = (prod_q[2] >>> FRAC_BITS) + (prod_q[3] >>> FRAC_BITS)
                     + prod_t'($signed(coef_i.ty));

        // Wrap to 16 bits
        assign result_o.x = sum_x[COORD_W-1:0];
        assign result_o.y = sum_y[COORD_W-1:0];

        assign result_valid_o = (state_q == ADD_SHIFT);
        assign busy_o         = (state_q != IDLE);

endmodule

`default_nettype wire

/* verilog/axf_regfile.sv */
// Bus write side of the affine transform unit
// Holds the control field, the six coefficients and the input point,
// and raises a one-cycle start when control is written with bit 0 set

`default_nettype none

module axf_regfile
        import axf_pkg::*;
(
        input  wire logic               clk,
        input  wire logic               rst_n,
        input  wire reg_addr_t          address_i,
        input  wire bus_data_t          data_in_i,
        input  wire write_size_t        data_write_n_i,
        output affine_coef_t            coef_o,
        output point_t                  point_o,
        output logic [CTRL_BITS-1:0]    ctrl_o,
        output logic                    start_o
);

        logic           write_en;
        coord_t         wr_val;         // Low half of the bus word
        affine_coef_t   coef_q;
        point_t         point_q;
        logic [CTRL_BITS-1:0] ctrl_q;

        // Any write size counts and only the low bits are kept
        assign write_en = (data_write_n_i != NO_WRITE);
        assign wr_val   = data_in_i[COORD_W-1:0];

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        coef_q  <= '0;
                        point_q <= '0;
                        ctrl_q  <= '0;
                end else if (write_en) begin
                        case (address_i)
                                ADDR_CONTROL: ctrl_q     <= data_in_i[CTRL_BITS-1:0];
                                ADDR_A:       coef_q.a   <= wr_val;
                                ADDR_B:       coef_q.b   <= wr_val;
                                ADDR_D:       coef_q.d   <= wr_val;
                                ADDR_E:       coef_q.e   <= wr_val;
                                ADDR_TX:      coef_q.tx  <= wr_val;
                                ADDR_TY:      coef_q.ty  <= wr_val;
                                ADDR_XIN:     point_q.x  <= wr_val;
                                ADDR_YIN:     point_q.y  <= wr_val;
                                default: ;              // Read-only or unmapped
                        endcase
                end
        end

        // Start is a pulse in the write cycle itself, so the engine
        // leaves IDLE on the same edge that stores the control field
        assign start_o = write_en && (address_i == ADDR_CONTROL) && data_in_i[0];

        assign coef_o  = coef_q;
        assign point_o = point_q;
        assign ctrl_o  = ctrl_q;

endmodule

`default_nettype wire

/* verilog/axf_pkg.sv */
// Shared definitions for the affine transform unit
// Widths and data types, bus register offsets, status bit positions,
// coefficient and point structs, engine state encoding

`default_nettype none

package axf_pkg;

        // Widths
        localparam int COORD_W   = 16;                  // Q8.8 value
        localparam int PROD_W    = 2 * COORD_W;         // Full signed product
        localparam int DATA_W    = 32;
        localparam int ADDR_W    = 6;
        localparam int FRAC_BITS = 8;
        localparam int CTRL_BITS = 3;
        localparam int MUL_STEPS = 4;                   // ax, by, dx, ey
        localparam int STEP_W    = $clog2(MUL_STEPS);

        typedef logic signed [COORD_W-1:0] coord_t;
        typedef logic signed [PROD_W-1:0]  prod_t;
        typedef logic [DATA_W-1:0]         bus_data_t;
        typedef logic [ADDR_W-1:0]         reg_addr_t;
        typedef logic [1:0]                write_size_t;
        typedef logic [STEP_W-1:0]         step_t;

        // Write size code when the core is not writing
        localparam write_size_t NO_WRITE = 2'b11;

        // Register map
        localparam reg_addr_t ADDR_CONTROL = 6'h00;
        localparam reg_addr_t ADDR_STATUS  = 6'h04;
        localparam reg_addr_t ADDR_A       = 6'h08;
        localparam reg_addr_t ADDR_B       = 6'h0C;
        localparam reg_addr_t ADDR_D       = 6'h10;
        localparam reg_addr_t ADDR_E       = 6'h14;
        localparam reg_addr_t ADDR_TX      = 6'h18;
        localparam reg_addr_t ADDR_TY      = 6'h1C;
        localparam reg_addr_t ADDR_XIN     = 6'h20;
        localparam reg_addr_t ADDR_YIN     = 6'h24;
        localparam reg_addr_t ADDR_XOUT    = 6'h28;
        localparam reg_addr_t ADDR_YOUT    = 6'h2C;

        // Status word layout
        localparam int STAT_DONE_BIT = 0;
        localparam int STAT_BUSY_BIT = 1;

        typedef struct packed {
                coord_t a;
                coord_t b;
                coord_t d;
                coord_t e;
                coord_t tx;
                coord_t ty;
        } affine_coef_t;

        typedef struct packed {
                coord_t x;
                coord_t y;
        } point_t;

        typedef enum logic [1:0] {
                IDLE      = 2'd0,
                MULT      = 2'd1,
                ADD_SHIFT = 2'd2
        } eng_state_t;

endpackage

`default_nettype wire
